//--- Bender.yml
package:
  name: render_seq

export_include_dirs:
  - src

sources:
  - src/renderPkg.sv
  - src/renderControl.sv
  - src/fillEngine.sv
  - src/rectEngine.sv
  - src/penCursor.sv
  - src/renderTop.sv
  - target: test
    files:
      - test/renderTb.sv

//--- list.f
+incdir+src
src/renderPkg.sv
src/renderControl.sv
src/fillEngine.sv
src/rectEngine.sv
src/penCursor.sv
src/renderTop.sv
test/renderTb.sv

//--- src/fillEngine.sv
// VRAM fill engine
// Walks the surface row by row and emits one fill command per segment,
// stalling whenever the command FIFO cannot take one

`timescale 1ns/100ps

module fillEngine import renderPkg::*; (
	input  logic     i_clk,
	input  logic     i_rst,
	input  logic     i_launch,       // One-cycle strobe from the control
	input  logic     i_emptySurface, // Zero width or height
	input  logic     i_cmdAccept,    // Fill FIFO has room
	input  logic     i_lastSegment,  // Current segment ends the row
	input  logic     i_lastRow,      // Current row is the bottom one
	output stepReq_t o_step,
	output logic     o_emitCmd,
	output logic     o_done
);

	typedef enum logic [1:0] {
		IDLE      = 2'd0,
		ROW_START = 2'd1, // Size test and cursor load
		ROW_FILL  = 2'd2  // One segment per accepted cycle
	} fillState_t;

	fillState_t currState, nextState;

	always_ff @(posedge i_clk) begin
		if (i_rst)
			currState <= IDLE;
		else
			currState <= nextState;
	end

	// ------------------------------
	// Segment walk
	// ------------------------------
	always_comb begin
		nextState = currState;
		o_step    = '{load: 1'b0, xSel: X_ASIS, ySel: Y_ASIS};
		o_emitCmd = 1'b0;
		o_done    = 1'b0;
		case (currState)
			IDLE: begin
				if (i_launch)
					nextState = ROW_START;
			end
			ROW_START: begin
				if (i_emptySurface) begin // Nothing to fill
					o_done    = 1'b1;
					nextState = IDLE;
				end else begin
					o_step    = '{load: 1'b1, xSel: X_LEFT, ySel: Y_TOP};
					nextState = ROW_FILL;
				end
			end
			ROW_FILL: begin
				if (i_cmdAccept) begin // Else hold the segment
					o_emitCmd = 1'b1;
					if (i_lastSegment) begin
						// Back to the left edge, one row down
						o_step = '{load: 1'b1, xSel: X_LEFT, ySel: Y_NEXT};
						if (i_lastRow) begin
							o_done    = 1'b1;
							nextState = IDLE;
						end
					end else begin
						o_step = '{load: 1'b1, xSel: X_NEXT_SEG, ySel: Y_ASIS};
					end
				end
			end
			default: nextState = IDLE;
		endcase
	end

endmodule

//--- src/penCursor.sv
// Pen cursor shared by both engines
// Holds the X/Y position, applies the active engine's step, derives the
// geometry flags and packs the position with the engine strobes

`timescale 1ns/100ps
`include "render_consts.svh"

module penCursor import renderPkg::*; (
	input  logic      i_clk,
	input  logic      i_rst,
	input  rectGeom_t i_geom,      // Held stable for the whole primitive
	input  stepReq_t  i_fillStep,
	input  stepReq_t  i_rectStep,
	input  logic      i_fillEmit,
	input  logic      i_writeL,
	input  logic      i_writeR,
	output logic      o_emptySurface,
	output logic      o_emptyRect,
	output logic      o_lastSegment,
	output logic      o_lastRow,
	output logic      o_rowHasPair,
	output logic      o_rowsRemain,
	output logic      o_inBoxL,
	output logic      o_inBoxR,
	output pixOut_t   o_pix,
	output fillCmd_t  o_fillCmd
);

	localparam coord_t SEG_STEP  = `FILL_SEG_PIX;
	localparam coord_t PAIR_STEP = `PAIR_PIX;
	localparam coord_t ROW_STEP  = 1;

	// One extra bit so edge sums never wrap
	localparam logic [`COORD_W:0] SEG_EXT = `FILL_SEG_PIX;
	localparam logic [`COORD_W:0] ONE_EXT = 1;

	coord_t              posX, posY;
	coord_t              leftEven;  // Rectangle left edge rounded down
	stepReq_t            step;      // Step of the active engine
	logic                loadAny;
	logic                emptyGeom;
	logic [`COORD_W:0]   xExt, yExt, x0Ext, xEnd, yEnd;

	assign loadAny  = i_fillStep.load | i_rectStep.load; // Only one engine runs
	assign step     = i_fillStep.load ? i_fillStep : i_rectStep;
	assign leftEven = {i_geom.x0[`COORD_W-1:1], 1'b0};

	// ------------------------------
	// Position registers
	// ------------------------------
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			posX <= '0;
			posY <= '0;
		end else if (loadAny) begin
			case (step.xSel)
				X_LEFT:      posX <= i_rectStep.load ? leftEven : i_geom.x0;
				X_NEXT_PAIR: posX <= posX + PAIR_STEP;
				X_NEXT_SEG:  posX <= posX + SEG_STEP;
				default:     posX <= posX;
			endcase
			case (step.ySel)
				Y_TOP:   posY <= i_geom.y0;
				Y_NEXT:  posY <= posY + ROW_STEP;
				default: posY <= posY;
			endcase
		end
	end

	// ------------------------------
	// Geometry flags
	// ------------------------------
	assign xExt  = {1'b0, posX};
	assign yExt  = {1'b0, posY};
	assign x0Ext = {1'b0, i_geom.x0};
	assign xEnd  = x0Ext + {1'b0, i_geom.width};          // Exclusive right edge
	assign yEnd  = {1'b0, i_geom.y0} + {1'b0, i_geom.height}; // Exclusive bottom

	assign emptyGeom      = (i_geom.width == '0) || (i_geom.height == '0);
	assign o_emptySurface = emptyGeom;
	assign o_emptyRect    = emptyGeom;

	assign o_lastSegment = (xExt + SEG_EXT) >= xEnd;
	assign o_lastRow     = (yExt + ONE_EXT) >= yEnd;
	assign o_rowsRemain  = yExt < yEnd;
	assign o_rowHasPair  = xExt < xEnd;
	assign o_inBoxL      = o_rowsRemain && (xExt >= x0Ext) && (xExt < xEnd);
	assign o_inBoxR      = o_rowsRemain && ((xExt + ONE_EXT) >= x0Ext)
	                       && ((xExt + ONE_EXT) < xEnd);

	// Outputs carry the position the engines acted on this cycle
	assign o_pix     = '{x: posX, y: posY, writeL: i_writeL, writeR: i_writeR};
	assign o_fillCmd = '{valid: i_fillEmit, x: posX, y: posY};

endmodule

//--- src/rectEngine.sv
// Flat rectangle engine
// Scans the rectangle in pixel pairs, one pair per request from the
// pixel pipeline, and drops pixels outside the box or under a set mask bit

`timescale 1ns/100ps

module rectEngine import renderPkg::*; (
	input  logic       i_clk,
	input  logic       i_rst,
	input  logic       i_launch,           // One-cycle strobe from the control
	input  logic       i_emptyRect,        // Zero width or height
	input  logic       i_requestNextPixel, // Pipeline takes a pair
	input  logic       i_rowHasPair,       // Pair left pixel before right edge
	input  logic       i_rowsRemain,       // Cursor row still inside
	input  logic       i_inBoxL,
	input  logic       i_inBoxR,
	input  logic       i_checkMask,
	input  logic [1:0] i_stencilRead,      // Bit 0 is the left pixel
	output stepReq_t   o_step,
	output logic       o_writeL,
	output logic       o_writeR,
	output logic       o_stencilRead,
	output logic       o_done,
	output logic       o_reject
);

	typedef enum logic [1:0] {
		IDLE       = 2'd0,
		RECT_START = 2'd1, // Size test and cursor load
		RECT_SCAN  = 2'd2  // Pair writes and row changes
	} rectState_t;

	rectState_t currState, nextState;
	logic       maskOkL, maskOkR;

	always_ff @(posedge i_clk) begin
		if (i_rst)
			currState <= IDLE;
		else
			currState <= nextState;
	end

	// Pixel may be drawn if masking is off or its stencil bit is clear
	assign maskOkL = !i_checkMask || !i_stencilRead[0];
	assign maskOkR = !i_checkMask || !i_stencilRead[1];

	// ------------------------------
	// Pair scan
	// ------------------------------
	always_comb begin
		nextState     = currState;
		o_step        = '{load: 1'b0, xSel: X_ASIS, ySel: Y_ASIS};
		o_writeL      = 1'b0;
		o_writeR      = 1'b0;
		o_stencilRead = 1'b0;
		o_done        = 1'b0;
		o_reject      = 1'b0;
		case (currState)
			IDLE: begin
				if (i_launch)
					nextState = RECT_START;
			end
			RECT_START: begin
				if (i_emptyRect) begin // Early reject, no pixel
					o_reject  = 1'b1;
					nextState = IDLE;
				end else begin
					o_stencilRead = 1'b1; // Fetch mask bits of the first pair
					o_step        = '{load: 1'b1, xSel: X_LEFT, ySel: Y_TOP};
					nextState     = RECT_SCAN;
				end
			end
			RECT_SCAN: begin
				o_stencilRead = 1'b1;
				if (!i_rowsRemain) begin // Past the bottom row
					o_done    = 1'b1;
					nextState = IDLE;
				end else if (i_rowHasPair) begin
					if (i_requestNextPixel) begin // Else hold the pair
						o_writeL = i_inBoxL && maskOkL;
						o_writeR = i_inBoxR && maskOkR;
						o_step   = '{load: 1'b1, xSel: X_NEXT_PAIR, ySel: Y_ASIS};
					end
				end else begin
					// Row end, no write this cycle
					o_step = '{load: 1'b1, xSel: X_LEFT, ySel: Y_NEXT};
				end
			end
			default: nextState = IDLE;
		endcase
	end

endmodule

//--- src/renderControl.sv
// Primitive sequencing for the drawing sequencer
// Latches the primitive at start, holds the launch until memory is quiet,
// then tracks the engine and runs the flush wait after a rectangle

`timescale 1ns/100ps

module renderControl import renderPkg::*; (
	input  logic      i_clk,
	input  logic      i_rst,
	input  logic      i_start,         // Pulse, only taken while idle
	input  primKind_t i_prim,
	input  logic      i_memBusy,       // Memory transaction running
	input  logic      i_pixelInFlight, // Pixel pipeline not drained yet
	input  logic      i_fillDone,
	input  logic      i_rectDone,
	input  logic      i_rectReject,
	output logic      o_launchFill,
	output logic      o_launchRect,
	output logic      o_flush,
	output logic      o_renderInactiveNextCycle,
	output logic      o_busy
);

	typedef enum logic [2:0] {
		IDLE       = 3'd0,
		WAIT_QUIET = 3'd1, // Wait for running memory transaction
		DISPATCH   = 3'd2, // Engine tests the size here
		RUNNING    = 3'd3,
		FLUSH_WAIT = 3'd4  // Rectangle only
	} ctrlState_t;

	ctrlState_t currState, nextState;
	primKind_t  primReg; // Kind latched at start
	logic       launch;

	// ------------------------------
	// State register
	// ------------------------------
	always_ff @(posedge i_clk) begin
		if (i_rst)
			currState <= IDLE;
		else
			currState <= nextState;
	end

	always_ff @(posedge i_clk) begin
		if (currState == IDLE && i_start)
			primReg <= i_prim;
	end

	// ------------------------------
	// Next state and strobes
	// ------------------------------
	always_comb begin
		nextState = currState;
		launch    = 1'b0;
		o_flush   = 1'b0;
		case (currState)
			IDLE: begin
				if (i_start)
					nextState = WAIT_QUIET;
			end
			WAIT_QUIET: begin
				if (!i_memBusy) begin // First quiet cycle fires the engine
					launch    = 1'b1;
					nextState = DISPATCH;
				end
			end
			DISPATCH: begin
				// Only an empty primitive can end in the size test cycle
				nextState = (i_fillDone || i_rectReject) ? IDLE : RUNNING;
			end
			RUNNING: begin
				if (i_rectDone)
					nextState = FLUSH_WAIT;
				else if (i_fillDone)
					nextState = IDLE; // Fill needs no flush
			end
			FLUSH_WAIT: begin
				// Memory idle and no pixel left in the pipeline
				if (!i_memBusy && !i_pixelInFlight) begin
					o_flush   = 1'b1;
					nextState = IDLE;
				end
			end
			default: nextState = IDLE;
		endcase
	end

	assign o_launchFill = launch && (primReg == PRIM_FILL);
	assign o_launchRect = launch && (primReg == PRIM_RECT);
	assign o_busy       = (currState != IDLE);

	// Last cycle of any primitive, rejected ones included
	assign o_renderInactiveNextCycle = (currState != IDLE) && (nextState == IDLE);

endmodule

//--- src/renderPkg.sv
// Shared types of the drawing sequencer
// Coordinates, cursor step selects and the structs passed between
// the control, the two engines and the pen cursor

`include "render_consts.svh"

package renderPkg;

	typedef logic [`COORD_W-1:0] coord_t; // One pixel coordinate

	typedef enum logic {
		PRIM_FILL = 1'b0, // VRAM fill, segment commands
		PRIM_RECT = 1'b1  // Flat rectangle, pixel pairs
	} primKind_t;

	// Next X choice for the cursor
	typedef enum logic [1:0] {
		X_ASIS      = 2'd0, // Hold
		X_LEFT      = 2'd1, // Left edge, even for a rectangle
		X_NEXT_PAIR = 2'd2, // Next pixel pair
		X_NEXT_SEG  = 2'd3  // Next fill segment
	} xSel_t;

	// Next Y choice for the cursor
	typedef enum logic [1:0] {
		Y_ASIS = 2'd0, // Hold
		Y_TOP  = 2'd1, // Top edge
		Y_NEXT = 2'd2  // Next row
	} ySel_t;

	typedef struct packed {
		coord_t x0;     // Left edge
		coord_t y0;     // Top edge
		coord_t width;  // Zero means nothing to draw
		coord_t height;
	} rectGeom_t;

	typedef struct packed {
		logic  load; // Apply the selects this cycle
		xSel_t xSel;
		ySel_t ySel;
	} stepReq_t;

	typedef struct packed {
		coord_t x;      // Pair X, even for a rectangle
		coord_t y;
		logic   writeL; // Left pixel of the pair
		logic   writeR; // Right pixel of the pair
	} pixOut_t;

	typedef struct packed {
		logic   valid; // Command pushed to the fill FIFO this cycle
		coord_t x;     // First pixel of the segment
		coord_t y;
	} fillCmd_t;

endpackage

//--- src/renderTop.sv
// Drawing sequencer top level
// Control, fill engine and rectangle engine share one pen cursor,
// which produces the pixel pair and fill command outputs

`timescale 1ns/100ps

module renderTop import renderPkg::*; (
	input  logic       i_clk,
	input  logic       i_rst,
	input  logic       i_start,
	input  primKind_t  i_prim,
	input  rectGeom_t  i_geom,
	input  logic       i_checkMask,
	input  logic [1:0] i_stencilRead,
	input  logic       i_cmdAccept,
	input  logic       i_requestNextPixel,
	input  logic       i_memBusy,
	input  logic       i_pixelInFlight,
	output pixOut_t    o_pix,
	output fillCmd_t   o_fillCmd,
	output logic       o_stencilRead,
	output logic       o_flush,
	output logic       o_renderInactiveNextCycle,
	output logic       o_busy
);

	logic     launchFill, launchRect;
	logic     fillDone, rectDone, rectReject;
	stepReq_t fillStep, rectStep;
	logic     fillEmit, writeL, writeR;
	logic     emptySurface, emptyRect, lastSegment, lastRow; // Cursor flags
	logic     rowHasPair, rowsRemain, inBoxL, inBoxR;

	renderControl u_renderControl (
		.i_clk(i_clk), .i_rst(i_rst), .i_start(i_start), .i_prim(i_prim),
		.i_memBusy(i_memBusy), .i_pixelInFlight(i_pixelInFlight),
		.i_fillDone(fillDone), .i_rectDone(rectDone), .i_rectReject(rectReject),
		.o_launchFill(launchFill), .o_launchRect(launchRect), .o_flush(o_flush),
		.o_renderInactiveNextCycle(o_renderInactiveNextCycle), .o_busy(o_busy)
	);

	fillEngine u_fillEngine (
		.i_clk(i_clk), .i_rst(i_rst), .i_launch(launchFill),
		.i_emptySurface(emptySurface), .i_cmdAccept(i_cmdAccept),
		.i_lastSegment(lastSegment), .i_lastRow(lastRow),
		.o_step(fillStep), .o_emitCmd(fillEmit), .o_done(fillDone)
	);

	rectEngine u_rectEngine (
		.i_clk(i_clk), .i_rst(i_rst), .i_launch(launchRect), .i_emptyRect(emptyRect),
		.i_requestNextPixel(i_requestNextPixel), .i_rowHasPair(rowHasPair),
		.i_rowsRemain(rowsRemain), .i_inBoxL(inBoxL), .i_inBoxR(inBoxR),
		.i_checkMask(i_checkMask), .i_stencilRead(i_stencilRead),
		.o_step(rectStep), .o_writeL(writeL), .o_writeR(writeR),
		.o_stencilRead(o_stencilRead), .o_done(rectDone), .o_reject(rectReject)
	);

	penCursor u_penCursor (
		.i_clk(i_clk), .i_rst(i_rst), .i_geom(i_geom),
		.i_fillStep(fillStep), .i_rectStep(rectStep), .i_fillEmit(fillEmit),
		.i_writeL(writeL), .i_writeR(writeR),
		.o_emptySurface(emptySurface), .o_emptyRect(emptyRect),
		.o_lastSegment(lastSegment), .o_lastRow(lastRow),
		.o_rowHasPair(rowHasPair), .o_rowsRemain(rowsRemain),
		.o_inBoxL(inBoxL), .o_inBoxR(inBoxR), .o_pix(o_pix), .o_fillCmd(o_fillCmd)
	);

endmodule

//--- src/render_consts.svh
// Size constants for the drawing sequencer
// Include wherever a coordinate width or a step size is needed
// Guarded so the package and the modules can all pull it in

`ifndef RENDER_CONSTS_SVH
`define RENDER_CONSTS_SVH

// ------------------------------
// Coordinates
// ------------------------------
`define COORD_W 10 // Bits in one X or Y coordinate

// ------------------------------
// Step sizes
// ------------------------------
`define FILL_SEG_PIX 8 // Pixels covered by one fill memory command
`define PAIR_PIX 2     // Pixels written per rectangle step

`endif

//--- test/renderTb.sv
// Testbench for the drawing sequencer
// Runs a table of fills and rectangles through renderTop, models the
// expected commands and pixel writes, and checks the control strobes

`timescale 1ns/100ps
`include "render_consts.svh"

module renderTb import renderPkg::*; ();

	localparam int NUM_VEC    = 12;
	localparam int WIN        = 64; // Model window, every vector fits inside
	localparam int MARGIN     = 4;  // Watchdog slack over the estimate
	localparam int CLK_PERIOD = 4;

	typedef struct packed {
		primKind_t  prim;
		coord_t     x0;
		coord_t     y0;
		coord_t     w;
		coord_t     h;
		logic       checkMask;
		logic [1:0] stencil;    // Held for the whole primitive
		logic [7:0] memHold;    // Busy cycles at start and after last write
		logic [7:0] flightHold; // In-flight cycles after last write
	} vec_t;

	logic       clk, rst, start;
	primKind_t  prim;
	rectGeom_t  geom;
	logic       checkMask, cmdAccept, reqPixel, memBusy, inFlight;
	logic [1:0] stencil;
	pixOut_t    pix;
	fillCmd_t   fillCmd;
	logic       stencilReq, flush, inactiveNext, busy;

	vec_t   vecTab [NUM_VEC];
	integer seed;
	int     errCount;
	logic   covered [0:WIN-1][0:WIN-1]; // Pixels written so far
	int     cmdCount, writeCount, flushCount, pulseCount;
	int     expCmds, expWrites, cyc, tailCyc;

	renderTop u_renderTop (
		.i_clk(clk), .i_rst(rst), .i_start(start), .i_prim(prim), .i_geom(geom),
		.i_checkMask(checkMask), .i_stencilRead(stencil), .i_cmdAccept(cmdAccept),
		.i_requestNextPixel(reqPixel), .i_memBusy(memBusy), .i_pixelInFlight(inFlight),
		.o_pix(pix), .o_fillCmd(fillCmd), .o_stencilRead(stencilReq), .o_flush(flush),
		.o_renderInactiveNextCycle(inactiveNext), .o_busy(busy)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ------------------------------
	// Stimulus table
	// ------------------------------
	task automatic loadTable();
		vecTab[0]  = '{PRIM_FILL, 3,  2,  20, 3, 1'b0, 2'b00, 0, 0}; // Partial last segment
		vecTab[1]  = '{PRIM_FILL, 0,  5,  16, 2, 1'b0, 2'b00, 5, 0}; // Launch wait
		vecTab[2]  = '{PRIM_RECT, 4,  1,  6,  3, 1'b0, 2'b00, 0, 3}; // Even x0, even width
		vecTab[3]  = '{PRIM_RECT, 5,  7,  7,  4, 1'b0, 2'b00, 3, 0}; // Odd x0, odd width
		vecTab[4]  = '{PRIM_RECT, 3,  0,  8,  2, 1'b0, 2'b00, 2, 6};
		vecTab[5]  = '{PRIM_RECT, 2,  10, 9,  3, 1'b1, 2'b01, 0, 2}; // Left pixels masked
		vecTab[6]  = '{PRIM_RECT, 7,  3,  5,  2, 1'b1, 2'b10, 1, 1}; // Right pixels masked
		vecTab[7]  = '{PRIM_RECT, 1,  1,  6,  2, 1'b1, 2'b00, 0, 0}; // Mask on, nothing set
		vecTab[8]  = '{PRIM_RECT, 0,  0,  4,  2, 1'b1, 2'b11, 0, 4}; // All masked, still flush
		vecTab[9]  = '{PRIM_FILL, 8,  8,  0,  4, 1'b0, 2'b00, 0, 0}; // Empty fill
		vecTab[10] = '{PRIM_RECT, 9,  9,  5,  0, 1'b0, 2'b00, 2, 0}; // Empty rectangle
		vecTab[11] = '{PRIM_FILL, 40, 60, 1,  1, 1'b0, 2'b00, 0, 0}; // Single command
	endtask

	// Pixel inside the box and not blocked by its stencil bit
	function automatic bit pixelAllowed(input vec_t v, input int x, input int y);
		if (x < v.x0 || x >= v.x0 + v.w || y < v.y0 || y >= v.y0 + v.h)
			return 1'b0;
		return !v.checkMask || !v.stencil[x % 2]; // Even X is the left pixel
	endfunction

	task automatic expectBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERR %s got %h exp %h", name, got, exp);
			errCount++;
		end
	endtask

	task automatic markPixel(input vec_t v, input int x, input int y);
		if (!pixelAllowed(v, x, y)) begin
			$display("Pixel (%0d,%0d) was written but must stay untouched", x, y);
			errCount++;
		end else if (covered[y][x]) begin
			$display("Pixel (%0d,%0d) was written twice", x, y);
			errCount++;
		end else begin
			covered[y][x] = 1'b1;
			writeCount++;
		end
	endtask

	// ------------------------------
	// Per-cycle checks at negedge
	// ------------------------------
	task automatic checkCycle(input vec_t v);
		int spr, k, expX, expY;
		spr = (v.w + `FILL_SEG_PIX - 1) / `FILL_SEG_PIX;
		// Launch in first quiet cycle, size test next, then first output
		if ((fillCmd.valid || pix.writeL || pix.writeR) && cyc < v.memHold + 3) begin
			$display("Output activity in cycle %0d, before the launch could happen", cyc);
			errCount++;
		end
		if (fillCmd.valid) begin
			if (v.prim != PRIM_FILL || !cmdAccept) begin
				$display("Fill command in cycle %0d without a fill or without accept", cyc);
				errCount++;
			end
			k = cmdCount;
			cmdCount++;
			if (k < expCmds) begin // Row-major segment order
				expX = v.x0 + `FILL_SEG_PIX * (k % spr);
				expY = v.y0 + k / spr;
				if (fillCmd.x !== coord_t'(expX)) begin
					$display("ERR o_fillCmd.x got %h exp %h", fillCmd.x, coord_t'(expX));
					errCount++;
				end
				if (fillCmd.y !== coord_t'(expY)) begin
					$display("ERR o_fillCmd.y got %h exp %h", fillCmd.y, coord_t'(expY));
					errCount++;
				end
			end
		end
		if (pix.writeL || pix.writeR) begin
			if (v.prim != PRIM_RECT || !reqPixel) begin
				$display("Pixel write in cycle %0d without a rectangle or request", cyc);
				errCount++;
			end
			if (!stencilReq) begin // Mask bits of the pair must be requested
				$display("Pair written in cycle %0d without a stencil request", cyc);
				errCount++;
			end
			if (pix.x[0]) begin // Pairs start on even X
				$display("Pixel pair in cycle %0d starts on odd X %0d", cyc, pix.x);
				errCount++;
			end
			if (pix.writeL)
				markPixel(v, int'(pix.x), int'(pix.y));
			if (pix.writeR)
				markPixel(v, int'(pix.x) + 1, int'(pix.y));
		end
		if (stencilReq && v.prim != PRIM_RECT) begin
			$display("Stencil request in cycle %0d during a fill", cyc);
			errCount++;
		end
		if (flush) begin
			flushCount++;
			if (memBusy || inFlight) begin
				$display("Flush pulse while memory busy or a pixel in flight");
				errCount++;
			end
		end
		if (inactiveNext)
			pulseCount++;
	endtask

	// ------------------------------
	// One table row, start to idle
	// ------------------------------
	task automatic applyVector(input vec_t v);
		int         spr;
		logic [31:0] rnd;
		bit         done, sawPulse, tailing;
		spr       = (v.w + `FILL_SEG_PIX - 1) / `FILL_SEG_PIX;
		expCmds   = (v.prim == PRIM_FILL) ? v.h * spr : 0;
		expWrites = 0;
		for (int y = 0; y < WIN; y++) begin
			for (int x = 0; x < WIN; x++) begin
				covered[y][x] = 1'b0;
				if (v.prim == PRIM_RECT && pixelAllowed(v, x, y))
					expWrites++;
			end
		end
		cmdCount   = 0;
		writeCount = 0;
		flushCount = 0;
		pulseCount = 0;
		cyc        = 0;
		tailCyc    = 0;
		done       = 1'b0;
		sawPulse   = 1'b0;
		@(posedge clk);
		start     <= 1'b1;
		prim      <= v.prim;
		geom      <= '{x0: v.x0, y0: v.y0, width: v.w, height: v.h};
		checkMask <= v.checkMask;
		stencil   <= v.stencil;
		memBusy   <= (v.memHold != 0);
		inFlight  <= (v.prim == PRIM_RECT);
		while (!done) begin
			@(negedge clk);
			checkCycle(v);
			if (sawPulse) begin
				expectBit("o_busy", busy, 1'b0); // Idle after the pulse
				done = 1'b1;
			end else if (inactiveNext) begin
				sawPulse = 1'b1;
				expectBit("o_busy", busy, 1'b1);
			end
			@(posedge clk);
			cyc++;
			rnd     = $random(seed);
			tailing = (v.prim == PRIM_RECT) && (writeCount == expWrites);
			start     <= 1'b0;
			cmdAccept <= rnd[0];
			reqPixel  <= rnd[1];
			// Busy at start, and again once all pixels are out
			memBusy  <= (v.memHold != 0 && cyc <= v.memHold) || (tailing && tailCyc < v.memHold);
			inFlight <= (v.prim == PRIM_RECT) && (!tailing || tailCyc < v.flightHold);
			if (tailing)
				tailCyc++;
		end
		if (cmdCount != expCmds) begin
			$display("ERR o_fillCmd.valid count got %h exp %h", cmdCount, expCmds);
			errCount++;
		end
		if (writeCount != expWrites) begin
			$display("ERR o_pix write count got %h exp %h", writeCount, expWrites);
			errCount++;
		end
		if (flushCount != int'(v.prim == PRIM_RECT && v.w != 0 && v.h != 0)) begin
			$display("ERR o_flush count got %h exp %h", flushCount,
				int'(v.prim == PRIM_RECT && v.w != 0 && v.h != 0));
			errCount++;
		end
		if (pulseCount != 1) begin
			$display("ERR o_renderInactiveNextCycle count got %h exp %h", pulseCount, 1);
			errCount++;
		end
	endtask

	// ------------------------------
	// Main sequence
	// ------------------------------
	initial begin
		loadTable();
		seed      = 32'h9bf5;
		errCount  = 0;
		rst       = 1'b1;
		start     = 1'b0;
		prim      = PRIM_FILL;
		geom      = '0;
		checkMask = 1'b0;
		stencil   = 2'b00;
		cmdAccept = 1'b0;
		reqPixel  = 1'b0;
		memBusy   = 1'b0;
		inFlight  = 1'b0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		expectBit("o_busy", busy, 1'b0); // All strobes quiet out of reset
		expectBit("o_flush", flush, 1'b0);
		expectBit("o_fillCmd.valid", fillCmd.valid, 1'b0);
		expectBit("o_stencilRead", stencilReq, 1'b0);
		expectBit("o_pix.writeL", pix.writeL, 1'b0);
		expectBit("o_pix.writeR", pix.writeR, 1'b0);
		expectBit("o_renderInactiveNextCycle", inactiveNext, 1'b0);
		for (int i = 0; i < NUM_VEC; i++)
			applyVector(vecTab[i]);
		$display("Errors: %0d", errCount);
		if (errCount == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	// Watchdog, estimate from areas, rows and hold times
	initial begin
		int limit;
		#1;
		limit = 20;
		for (int i = 0; i < NUM_VEC; i++)
			limit += vecTab[i].w * vecTab[i].h + 4 * vecTab[i].h + 2 * vecTab[i].memHold
				+ vecTab[i].flightHold + 20;
		#(limit * MARGIN * CLK_PERIOD);
		$display("Watchdog expired, the run did not finish in time");
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule
